//--- Makefile
SIM  := obj_dir/Vtb_wb_top
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_top -f list.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/mem_conflict.sv
// flags a younger load whose byte range overlaps any store still pending in the buffer
`timescale 1ns/1ps
`default_nettype none

module mem_conflict import wb_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic [ADDR_W-1:0] ld_start_i,
  input  logic [ADDR_W-1:0] ld_end_i,
  wb_range_if.sink          ranges,
  input  logic [ADDR_W-1:0] hold_start_i,
  input  logic [ADDR_W-1:0] hold_end_i,
  input  logic              hold_valid_i,
  output logic              conflict_o
);

  logic [DEPTH-1:0] fifo_hit;
  logic             hold_hit;
  logic             drn_hit;

  // inclusive ranges overlap unless one ends before the other starts
  function automatic logic overlap(wb_addr_t a_s, wb_addr_t a_e,
                                   wb_addr_t b_s, wb_addr_t b_e);
    return (a_s <= b_e) && (b_s <= a_e);
  endfunction

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      fifo_hit[i] = ranges.valid[i] &&
                    overlap(ld_start_i, ld_end_i, ranges.start_a[i], ranges.end_a[i]);
    end
  end

  assign hold_hit = hold_valid_i && overlap(ld_start_i, ld_end_i, hold_start_i, hold_end_i);
  assign drn_hit  = ranges.drn_valid &&
                    overlap(ld_start_i, ld_end_i, ranges.drn_start, ranges.drn_end);

  assign conflict_o = (|fifo_hit) || hold_hit || drn_hit;

endmodule

`default_nettype wire

//--- hdl/store_decode.sv
// APB write slave and decode stage, turns each accepted store into a buffer entry
`timescale 1ns/1ps
`default_nettype none

module store_decode import wb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [ADDR_W-1:0]  paddr_i,
  input  logic [DATA_W-1:0]  pwdata_i,
  input  logic [STRB_W-1:0]  pstrb_i,
  output logic               pready_o,
  output logic               pslverr_o,
  wb_entry_if.producer       out,
  output logic [ADDR_W-1:0]  hold_start_o,
  output logic [ADDR_W-1:0]  hold_end_o,
  output logic               hold_valid_o
);

  localparam int CNT_W = $clog2(STRB_W + 1);

  logic              valid_q;
  wb_entry_t         entry_q;
  logic [CNT_W-1:0]  strb_cnt;
  logic [STRB_W-1:0] strb_inc;
  logic              strb_ok;
  logic              bad_xfer;
  logic              capture;
  wb_addr_t          end_addr;

  // number of set strobes
  always_comb begin
    strb_cnt = '0;
    for (int b = 0; b < STRB_W; b++) begin
      strb_cnt = strb_cnt + CNT_W'(pstrb_i[b]);
    end
  end

  // contiguous from bit 0 means strb+1 is a power of two
  assign strb_inc = pstrb_i + 1'b1;
  assign strb_ok  = (pstrb_i != '0) && ((pstrb_i & strb_inc) == '0);
  assign end_addr = paddr_i + wb_addr_t'(strb_cnt) - wb_addr_t'(1);

  // access phase completes only while the stage is empty
  assign pready_o  = psel_i && penable_i && !valid_q;
  assign bad_xfer  = !pwrite_i || !strb_ok;
  assign pslverr_o = pready_o && bad_xfer;
  assign capture   = pready_o && !bad_xfer;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      entry_q.start_addr <= paddr_i;
      entry_q.end_addr   <= end_addr;
      entry_q.data       <= pwdata_i;
      entry_q.strb       <= pstrb_i;
    end
  end

  assign out.valid = valid_q;
  assign out.entry = entry_q;

  // held store still counts for load conflicts
  assign hold_start_o = entry_q.start_addr;
  assign hold_end_o   = entry_q.end_addr;
  assign hold_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hdl/wb_drain.sv
// drain stage, writes the oldest buffered store to data memory and waits for its ack
`timescale 1ns/1ps
`default_nettype none

module wb_drain import wb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,
  wb_entry_if.consumer       in,
  output logic               mem_we_o,
  output logic [ADDR_W-1:0]  mem_addr_o,
  output logic [DATA_W-1:0]  mem_wdata_o,
  output logic [STRB_W-1:0]  mem_strb_o,
  input  logic               mem_ack_i,
  output logic [ADDR_W-1:0]  rng_start_o,
  output logic [ADDR_W-1:0]  rng_end_o,
  output logic               busy_o
);

  logic      we_q;
  wb_entry_t cur_q;
  logic      take;

  // free when idle, or on the edge that retires the current write
  assign in.ready = !we_q || mem_ack_i;
  assign take     = in.valid && in.ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      we_q <= 1'b0;
    end else if (take) begin
      we_q <= 1'b1;
    end else if (mem_ack_i) begin
      we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cur_q <= in.entry;
    end
  end

  // write fields hold until ack
  assign mem_we_o    = we_q;
  assign mem_addr_o  = cur_q.start_addr;
  assign mem_wdata_o = cur_q.data;
  assign mem_strb_o  = cur_q.strb;

  // store in flight is still a pending range for loads
  assign rng_start_o = cur_q.start_addr;
  assign rng_end_o   = cur_q.end_addr;
  assign busy_o      = we_q;

endmodule

`default_nettype wire

//--- hdl/wb_entry_if.sv
// valid/ready link carrying one store entry between two pipeline stages
`timescale 1ns/1ps
`default_nettype none

interface wb_entry_if import wb_pkg::*; ();

  // producer holds valid and entry steady until valid and ready meet on an edge
  logic      valid;
  logic      ready;
  wb_entry_t entry;

  modport producer (
    output valid,
    output entry,
    input  ready
  );

  modport consumer (
    input  valid,
    input  entry,
    output ready
  );

endinterface

`default_nettype wire

//--- hdl/wb_pkg.sv
// shared widths and the store entry layout, imported by every module of the write buffer
`default_nettype none

package wb_pkg;

  // byte address width of the store buffer and the data memory port
  localparam int ADDR_W = 15;

  // store data and byte strobes
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] wb_addr_t;

  // one buffered store, 66 bits
  // start_addr is the first byte written, end_addr the last one
  typedef struct packed {
    wb_addr_t            start_addr;
    wb_addr_t            end_addr;
    logic [DATA_W-1:0]   data;
    logic [STRB_W-1:0]   strb;
  } wb_entry_t;

endpackage

`default_nettype wire

//--- hdl/wb_range_if.sv
// address ranges of buffered stores, from the FIFO and drain to the conflict checker
`timescale 1ns/1ps
`default_nettype none

interface wb_range_if import wb_pkg::*; #(
  parameter int DEPTH = 4
) ();

  // one range per FIFO slot, valid mask follows rd pointer and count
  wb_addr_t [DEPTH-1:0] start_a;
  wb_addr_t [DEPTH-1:0] end_a;
  logic     [DEPTH-1:0] valid;

  // extra slot for the store sitting in the drain
  wb_addr_t             drn_start;
  wb_addr_t             drn_end;
  logic                 drn_valid;

  modport source (output start_a, output end_a, output valid);

  modport sink (
    input start_a, input end_a, input valid,
    input drn_start, input drn_end, input drn_valid
  );

endinterface

`default_nettype wire

//--- hdl/wb_top.sv
// top of the store write buffer, instantiate this with plain APB, load and memory ports
`timescale 1ns/1ps
`default_nettype none

module wb_top import wb_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // APB slave, writes only
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [ADDR_W-1:0]            paddr_i,
  input  logic [DATA_W-1:0]            pwdata_i,
  input  logic [STRB_W-1:0]            pstrb_i,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // load range check
  input  logic [ADDR_W-1:0]            ld_start_i,
  input  logic [ADDR_W-1:0]            ld_end_i,
  output logic                         conflict_o,
  // data memory port
  output logic                         mem_we_o,
  output logic [ADDR_W-1:0]            mem_addr_o,
  output logic [DATA_W-1:0]            mem_wdata_o,
  output logic [STRB_W-1:0]            mem_strb_o,
  input  logic                         mem_ack_i,
  output logic [$clog2(DEPTH+1)-1:0]   fifo_cnt_o
);

  logic [ADDR_W-1:0] hold_start;
  logic [ADDR_W-1:0] hold_end;
  logic              hold_valid;

  wb_entry_if                   dec_if ();
  wb_entry_if                   drn_if ();
  wb_range_if #(.DEPTH(DEPTH))  rng_if ();

  store_decode u_decode (
    .clk, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .pstrb_i,
    .pready_o, .pslverr_o, .out(dec_if),
    .hold_start_o(hold_start), .hold_end_o(hold_end), .hold_valid_o(hold_valid)
  );

  wr_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk, .rst_n_i, .in(dec_if), .out(drn_if), .ranges(rng_if), .fifo_cnt_o
  );

  wb_drain u_drain (
    .clk, .rst_n_i, .in(drn_if),
    .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_strb_o, .mem_ack_i,
    .rng_start_o(rng_if.drn_start), .rng_end_o(rng_if.drn_end), .busy_o(rng_if.drn_valid)
  );

  mem_conflict #(.DEPTH(DEPTH)) u_conflict (
    .ld_start_i, .ld_end_i, .ranges(rng_if),
    .hold_start_i(hold_start), .hold_end_i(hold_end), .hold_valid_i(hold_valid),
    .conflict_o
  );

endmodule

`default_nettype wire

//--- hdl/wr_fifo.sv
// circular write FIFO of store entries, exposes every slot's range to the conflict checker
`timescale 1ns/1ps
`default_nettype none

module wr_fifo import wb_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  wb_entry_if.consumer                 in,
  wb_entry_if.producer                 out,
  wb_range_if.source                   ranges,
  output logic [$clog2(DEPTH+1)-1:0]   fifo_cnt_o
);

  // depth must be a power of two so the pointers wrap by themselves
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  wb_entry_t        mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;
  logic [PTR_W-1:0] slot_ofs;

  assign full  = (cnt_q == CNT_W'(DEPTH));
  assign empty = (cnt_q == '0);

  assign in.ready  = !full;
  assign out.valid = !empty;
  assign out.entry = mem_q[rd_ptr_q];

  assign wr_en = in.valid && in.ready;
  assign rd_en = out.valid && out.ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together keep the count
      case ({wr_en, rd_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= in.entry;
    end
  end

  // a slot is live when its distance from the head is below the count
  always_comb begin
    slot_ofs = '0;
    for (int i = 0; i < DEPTH; i++) begin
      slot_ofs            = PTR_W'(i) - rd_ptr_q;
      ranges.start_a[i]   = mem_q[i].start_addr;
      ranges.end_a[i]     = mem_q[i].end_addr;
      ranges.valid[i]     = (CNT_W'(slot_ofs) < cnt_q);
    end
  end

  assign fifo_cnt_o = cnt_q;

endmodule

`default_nettype wire

//--- list.f
hdl/wb_pkg.sv
hdl/wb_entry_if.sv
hdl/wb_range_if.sv
hdl/store_decode.sv
hdl/wr_fifo.sv
hdl/mem_conflict.sv
hdl/wb_drain.sv
hdl/wb_top.sv
tb/wb_chk.sv
tb/tb_wb_top.sv

//--- tb/tb_wb_top.sv
// directed testbench for the store write buffer, compiled from list.f and run by the Makefile
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top import wb_pkg::*; ();

  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  wb_addr_t                   paddr;
  logic [DATA_W-1:0]          pwdata;
  logic [STRB_W-1:0]          pstrb;
  logic                       pready;
  logic                       pslverr;
  wb_addr_t                   ld_start;
  wb_addr_t                   ld_end;
  logic                       conflict;
  logic                       mem_we;
  wb_addr_t                   mem_addr;
  logic [DATA_W-1:0]          mem_wdata;
  logic [STRB_W-1:0]          mem_strb;
  logic                       mem_ack = 1'b0;
  logic [$clog2(DEPTH+1)-1:0] fifo_cnt;

  // memory model state
  logic [7:0] mem_b [2**ADDR_W];
  logic       ack_hold;
  int         ack_delay;
  int         wait_cnt = 0;
  int         wr_cnt = 0;
  wb_entry_t  ack_ent;

  // accepted stores not yet written, oldest first
  wb_entry_t  pend_q [$];
  wb_addr_t   ld_s [$];
  wb_addr_t   ld_e [$];
  string      test_name;
  int         seed = 79336;

  wb_top #(.DEPTH(DEPTH)) dut0 (
    .clk(clk), .rst_n_i(rst_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .pstrb_i(pstrb), .pready_o(pready), .pslverr_o(pslverr),
    .ld_start_i(ld_start), .ld_end_i(ld_end), .conflict_o(conflict),
    .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_strb_o(mem_strb), .mem_ack_i(mem_ack), .fifo_cnt_o(fifo_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] fill_byte(int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
  endfunction

  // end byte is start plus number of set strobes minus one
  function automatic wb_entry_t make_entry(wb_addr_t a, logic [DATA_W-1:0] d,
                                           logic [STRB_W-1:0] s);
    wb_entry_t e;
    int        n;
    n = 0;
    for (int b = 0; b < STRB_W; b++) begin
      n += int'(s[b]);
    end
    e.start_addr = a;
    e.end_addr   = a + wb_addr_t'(n - 1);
    e.data       = d;
    e.strb       = s;
    return e;
  endfunction

  // load hits when it starts at or before a store's end and ends at or after its start
  function automatic logic expect_conflict(wb_addr_t ls, wb_addr_t le);
    logic hit;
    hit = 1'b0;
    foreach (pend_q[i]) begin
      if (ls <= pend_q[i].end_addr && pend_q[i].start_addr <= le) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act));
    end
  endtask

  task automatic commit_write(input wb_entry_t got);
    wb_entry_t want;
    if (pend_q.size() == 0) begin
      abort_run($sformatf("memory write with no store pending in test %s", test_name));
    end
    want = pend_q.pop_front();
    check("mem_addr", want.start_addr, got.start_addr);
    check("mem_wdata", want.data, got.data);
    check("mem_strb", want.strb, got.strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (got.strb[b]) begin
        mem_b[got.start_addr + wb_addr_t'(b)] = got.data[8*b +: 8];
      end
    end
    wr_cnt++;
  endtask

  // ack one cycle long, after ack_delay cycles of mem_we
  always @(negedge clk) begin
    if (mem_ack) begin
      commit_write(ack_ent);
      mem_ack  = 1'b0;
      wait_cnt = 0;
    end else if (mem_we && !ack_hold) begin
      if (wait_cnt >= ack_delay) begin
        ack_ent.start_addr = mem_addr;
        ack_ent.end_addr   = mem_addr;
        ack_ent.data       = mem_wdata;
        ack_ent.strb       = mem_strb;
        mem_ack            = 1'b1;
      end else begin
        wait_cnt++;
      end
    end
  end

  task automatic apb_setup(input logic wr, input wb_addr_t a, input logic [DATA_W-1:0] d,
                           input logic [STRB_W-1:0] s);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    pstrb   = s;
    @(negedge clk);
    penable = 1'b1;
  endtask

  // access phase ends on the edge after pready is seen
  task automatic apb_finish(output logic err);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      #1;
      if (pready) begin
        done = 1'b1;
        err  = pslverr;
      end else if (n >= TIMEOUT) begin
        abort_run($sformatf("APB access never completed in test %s", test_name));
      end
      n++;
      @(negedge clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_store(input wb_addr_t a, input logic [DATA_W-1:0] d,
                           input logic [STRB_W-1:0] s);
    logic err;
    apb_setup(1'b1, a, d, s);
    apb_finish(err);
    check("pslverr", 0, err);
    pend_q.push_back(make_entry(a, d, s));
  endtask

  task automatic apb_reject(input logic wr, input wb_addr_t a, input logic [STRB_W-1:0] s);
    logic err;
    apb_setup(wr, a, 32'h1234_5678, s);
    apb_finish(err);
    check("pslverr", 1, err);
  endtask

  task automatic load_check(input wb_addr_t ls, input wb_addr_t le);
    @(negedge clk);
    ld_start = ls;
    ld_end   = le;
    #1;
    check("conflict", expect_conflict(ls, le), conflict);
  endtask

  task automatic add_load(input wb_addr_t ls, input wb_addr_t le);
    ld_s.push_back(ls);
    ld_e.push_back(le);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        abort_run($sformatf("buffer did not drain in test %s", test_name));
      end
    end while (pend_q.size() != 0 || fifo_cnt != 0 || mem_we);
  endtask

  task automatic test_single();
    wb_addr_t          a;
    logic [DATA_W-1:0] d;
    int                n0;
    test_name = "single";
    ack_hold  = 1'b0;
    ack_delay = 2;
    a  = wb_addr_t'($random(seed)) & 15'h3ff0;
    d  = $random(seed);
    n0 = wr_cnt;
    apb_store(a, d, 4'h7);
    wait_idle();
    check("write_count", n0 + 1, wr_cnt);
    for (int b = 0; b < 3; b++) begin
      check("mem_byte", d[8*b +: 8], mem_b[a + wb_addr_t'(b)]);
    end
    check("mem_untouched", fill_byte(int'(a) + 3), mem_b[a + wb_addr_t'(3)]);
  endtask

  task automatic test_strobe();
    int n0;
    test_name = "strobe";
    n0 = wr_cnt;
    apb_reject(1'b0, 15'h0200, 4'hf);
    apb_reject(1'b1, 15'h0204, 4'h0);
    apb_reject(1'b1, 15'h0208, 4'h5);
    apb_reject(1'b1, 15'h020c, 4'he);
    wait_idle();
    check("write_count", n0, wr_cnt);
    check("fifo_cnt", 0, fifo_cnt);
  endtask

  // one store in drain, DEPTH in the FIFO, one in decode, the next one must stall
  task automatic test_fill();
    logic [DATA_W-1:0] d;
    logic              err;
    int                n0;
    test_name = "fill";
    ack_hold  = 1'b1;
    ack_delay = 0;
    n0 = wr_cnt;
    for (int i = 0; i < DEPTH + 2; i++) begin
      d = $random(seed);
      apb_store(15'h1000 + wb_addr_t'(8 * i), d, 4'hf);
    end
    d = $random(seed);
    apb_setup(1'b1, 15'h1100, d, 4'h3);
    for (int i = 0; i < 8; i++) begin
      #1;
      check("pready_stall", 0, pready);
      check("fifo_cnt_full", DEPTH, fifo_cnt);
      @(negedge clk);
    end
    // loads on every pending range, the store held in decode included
    foreach (pend_q[i]) begin
      load_check(pend_q[i].start_addr, pend_q[i].end_addr);
    end
    check("write_count_held", n0, wr_cnt);
    ack_hold = 1'b0;
    apb_finish(err);
    check("pslverr", 0, err);
    pend_q.push_back(make_entry(15'h1100, d, 4'h3));
    wait_idle();
    check("write_count", n0 + DEPTH + 3, wr_cnt);
  endtask

  task automatic test_conflict();
    wb_addr_t s;
    wb_addr_t e;
    test_name = "conflict";
    ack_hold  = 1'b1;
    ack_delay = 1;
    apb_store(15'h2000, $random(seed), 4'hf);
    apb_store(15'h2010, $random(seed), 4'h7);
    apb_store(15'h2020, $random(seed), 4'hf);
    foreach (pend_q[i]) begin
      s = pend_q[i].start_addr;
      e = pend_q[i].end_addr;
      add_load(s, s);
      add_load(e, e);
      add_load(s + 15'd1, e - 15'd1);
      add_load(s - 15'd2, s - 15'd1);
      add_load(e + 15'd1, e + 15'd2);
    end
    foreach (ld_s[i]) begin
      load_check(ld_s[i], ld_e[i]);
    end
  endtask

  task automatic test_drain();
    test_name = "drain";
    ack_hold  = 1'b0;
    wait_idle();
    foreach (ld_s[i]) begin
      load_check(ld_s[i], ld_e[i]);
    end
    check("fifo_cnt", 0, fifo_cnt);
  endtask

  initial begin
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    ld_start  = '0;
    ld_end    = '0;
    ack_hold  = 1'b0;
    ack_delay = 0;
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem_b[i] = fill_byte(i);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    #1;
    test_name = "reset";
    check("pready", 0, pready);
    check("pslverr", 0, pslverr);
    check("mem_we", 0, mem_we);
    check("conflict", 0, conflict);
    check("fifo_cnt", 0, fifo_cnt);
    test_single();
    test_strobe();
    test_fill();
    test_conflict();
    test_drain();
    // bound assertions count their own failures
    if (dut0.u_chk.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/wb_chk.sv
// assertions on the APB response, memory write hold and FIFO count, bound into wb_top
`timescale 1ns/1ps
`default_nettype none

module wb_chk import wb_pkg::*; #(
  parameter int DEPTH = 4
) (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       pwrite_i,
  input logic [STRB_W-1:0]          pstrb_i,
  input logic                       pready_i,
  input logic                       pslverr_i,
  input logic                       mem_we_i,
  input logic                       mem_ack_i,
  input logic [ADDR_W-1:0]          mem_addr_i,
  input logic [DATA_W-1:0]          mem_wdata_i,
  input logic [STRB_W-1:0]          mem_strb_i,
  input logic [$clog2(DEPTH+1)-1:0] fifo_cnt_i
);

  // assertion failures so far
  int fail_cnt = 0;

  // error only on a completing read or a strobe pattern other than 1 to 4 low bytes
  a_slverr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pslverr_i == (pready_i && (!pwrite_i || !(pstrb_i inside {4'h1, 4'h3, 4'h7, 4'hf}))))
    else begin
      fail_cnt++;
      $error("pslverr does not match the access and its strobes");
    end

  // write request holds its fields until the ack
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_we_i && !mem_ack_i |=> mem_we_i && $stable(mem_addr_i) &&
                               $stable(mem_wdata_i) && $stable(mem_strb_i))
    else begin
      fail_cnt++;
      $error("memory write changed before its ack");
    end

  a_cnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) fifo_cnt_i <= DEPTH)
    else begin
      fail_cnt++;
      $error("FIFO count above its depth");
    end

endmodule

bind wb_top wb_chk #(.DEPTH(DEPTH)) u_chk (
  .clk_i(clk), .rst_n_i(rst_n_i), .pwrite_i(pwrite_i), .pstrb_i(pstrb_i),
  .pready_i(pready_o), .pslverr_i(pslverr_o),
  .mem_we_i(mem_we_o), .mem_ack_i(mem_ack_i), .mem_addr_i(mem_addr_o),
  .mem_wdata_i(mem_wdata_o), .mem_strb_i(mem_strb_o), .fifo_cnt_i(fifo_cnt_o)
);

`default_nettype wire
